/* Bender.yml */
package:
  name: rotation_check

sources:
  # packages first, then the design from the leaves up
  - src/boardPkg.sv
  - src/piecePkg.sv
  - src/cellLookup.sv
  - src/rotationProbe.sv
  - src/rotationVerdict.sv
  - src/rotationCheck.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/rotationCheck_asserts.sv
      - tb/rotationCheckTb.sv

/* src/boardPkg.sv */
`default_nettype none

package boardPkg;

    // playfield size
    localparam int boardWidth = 10;
    localparam int boardHeight = 20;
    localparam int boardCells = boardWidth * boardHeight;

    // column 0..9, row 0..19 with row 0 at the top
    typedef logic [3:0] colT;
    typedef logic [4:0] rowT;

    // bit index is row * boardWidth + col, 1 means occupied
    typedef logic [boardCells-1:0] boardT;

    typedef struct packed {
        rowT row;
        colT col;
    } cellPosT;

endpackage

`default_nettype wire

/* src/cellLookup.sv */
`timescale 1ns/1ps
`default_nettype none

module cellLookup
    import boardPkg::*, piecePkg::*;
(
    input  boardT   board,
    input  cellPosT pivot,
    input  offsetT  offset,
    output logic    free
);

    logic signed [6:0] rowSum;
    logic signed [6:0] colSum;
    logic signed [6:0] colWrapped;
    logic              rowInside;
    colT               targetCol;
    logic [7:0]        cellIndex;

    always_comb begin
        rowSum = $signed({2'b00, pivot.row}) + $signed({{4{offset.dRow[2]}}, offset.dRow});
        colSum = $signed({3'b000, pivot.col}) + $signed({{4{offset.dCol[2]}}, offset.dCol});

        // columns wrap around the side walls
        if (colSum < 0) begin
            colWrapped = colSum + 7'(boardWidth);
        end else if (colSum >= boardWidth) begin
            colWrapped = colSum - 7'(boardWidth);
        end else begin
            colWrapped = colSum;
        end
        targetCol = colWrapped[3:0];

        // rows off the top or bottom are blocked
        rowInside = (rowSum >= 0) && (rowSum < boardHeight);
        cellIndex = 8'(rowSum[4:0]) * 8'(boardWidth) + 8'(targetCol);
    end

    assign free = rowInside && !board[cellIndex];

endmodule

`default_nettype wire

/* src/piecePkg.sv */
`default_nettype none

package piecePkg;

    import boardPkg::*;

    // angle steps for the two turn directions
    localparam int turnClockwise = 1;
    localparam int turnCounterclockwise = 3;

    typedef enum logic [2:0] {
        pieceO,
        pieceL,
        pieceJ,
        pieceS,
        pieceZ,
        pieceI,
        pieceT
    } pieceKindT;

    // next angle is angle + 1 modulo 4
    typedef enum logic [1:0] {
        angle0,
        angle90,
        angle180,
        angle270
    } angleT;

    // positive dRow points down, positive dCol points right
    typedef struct packed {
        logic signed [2:0] dRow;
        logic signed [2:0] dCol;
    } offsetT;

    typedef offsetT [3:0] shapeT;

    typedef struct packed {
        pieceKindT kind;
        angleT     angle;
        cellPosT   pivot;
    } pieceStateT;

    function automatic offsetT mkOffset(input int dRow, input int dCol);
        offsetT o;
        o.dRow = 3'(dRow);
        o.dCol = 3'(dCol);
        return o;
    endfunction

    // quarter turn clockwise about the pivot, (r, c) -> (c, -r)
    function automatic shapeT rotateCw(input shapeT s);
        shapeT r;
        for (int i = 0; i < 4; i++) begin
            r[i].dRow = s[i].dCol;
            r[i].dCol = -s[i].dRow;
        end
        return r;
    endfunction

    // spawn orientation, pivot cell always in slot 1
    function automatic shapeT baseShape(input pieceKindT kind);
        shapeT s;
        s[1] = mkOffset(0, 0);
        case (kind)
            pieceL: begin
                s[0] = mkOffset(0, -1);
                s[2] = mkOffset(0, 1);
                s[3] = mkOffset(-1, 1);
            end
            pieceJ: begin
                s[0] = mkOffset(0, -1);
                s[2] = mkOffset(0, 1);
                s[3] = mkOffset(-1, -1);
            end
            pieceS: begin
                s[0] = mkOffset(0, -1);
                s[2] = mkOffset(-1, 0);
                s[3] = mkOffset(-1, 1);
            end
            pieceZ: begin
                s[0] = mkOffset(-1, -1);
                s[2] = mkOffset(-1, 0);
                s[3] = mkOffset(0, 1);
            end
            pieceI: begin
                s[0] = mkOffset(0, -1);
                s[2] = mkOffset(0, 1);
                s[3] = mkOffset(0, 2);
            end
            pieceT: begin
                s[0] = mkOffset(0, -1);
                s[2] = mkOffset(0, 1);
                s[3] = mkOffset(-1, 0);
            end
            default: begin
                // O square hangs down and right of the pivot
                s[0] = mkOffset(0, 1);
                s[2] = mkOffset(1, 0);
                s[3] = mkOffset(1, 1);
            end
        endcase
        return s;
    endfunction

    function automatic shapeT shapeOf(input pieceKindT kind, input angleT angle);
        shapeT shape;
        shape = baseShape(kind);
        // O keeps its cells at every angle
        if (kind != pieceO) begin
            for (int step = 0; step < 3; step++) begin
                if (step < int'(angle)) begin
                    shape = rotateCw(shape);
                end
            end
        end
        return shape;
    endfunction

endpackage

`default_nettype wire

/* src/rotationCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module rotationCheck
    import boardPkg::*, piecePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  boardT      board,
    input  pieceStateT piece,
    output logic       validClockwise,
    output logic       validCounterclockwise
);

    logic [3:0] cwFree;
    logic [3:0] ccwFree;

    // both directions are probed side by side
    rotationProbe #(
        .turnStep(turnClockwise)
    ) cwProbe (
        .board   (board),
        .piece   (piece),
        .cellFree(cwFree)
    );

    // three clockwise steps equal one counterclockwise step
    rotationProbe #(
        .turnStep(turnCounterclockwise)
    ) ccwProbe (
        .board   (board),
        .piece   (piece),
        .cellFree(ccwFree)
    );

    rotationVerdict verdict0 (
        .clk                  (clk),
        .rst                  (rst),
        .cwFree               (cwFree),
        .ccwFree              (ccwFree),
        .validClockwise       (validClockwise),
        .validCounterclockwise(validCounterclockwise)
    );

endmodule

`default_nettype wire

/* src/rotationProbe.sv */
`timescale 1ns/1ps
`default_nettype none

module rotationProbe
    import boardPkg::*, piecePkg::*;
#(
    parameter int turnStep = turnClockwise
) (
    input  boardT      board,
    input  pieceStateT piece,
    output logic [3:0] cellFree
);

    angleT      targetAngle;
    shapeT      targetShape;
    logic [3:0] lookupFree;
    logic       squarePiece;

    // angle after the turn, wraps modulo four
    assign targetAngle = angleT'(piece.angle + 2'(turnStep));
    assign targetShape = shapeOf(piece.kind, targetAngle);

    // one board read per target cell
    for (genvar i = 0; i < 4; i++) begin : gLookup
        cellLookup lookup (
            .board (board),
            .pivot (piece.pivot),
            .offset(targetShape[i]),
            .free  (lookupFree[i])
        );
    end

    // O looks the same after any turn
    assign squarePiece = (piece.kind == pieceO);
    assign cellFree = squarePiece ? 4'b1111 : lookupFree;

endmodule

`default_nettype wire

/* src/rotationVerdict.sv */
`timescale 1ns/1ps
`default_nettype none

module rotationVerdict (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] cwFree,
    input  logic [3:0] ccwFree,
    output logic       validClockwise,
    output logic       validCounterclockwise
);

    logic cwAllFree;
    logic ccwAllFree;

    // a turn needs all four target cells
    assign cwAllFree = &cwFree;
    assign ccwAllFree = &ccwFree;

    always_ff @(posedge clk) begin
        if (rst) begin
            validClockwise <= 1'b0;
            validCounterclockwise <= 1'b0;
        end else begin
            validClockwise <= cwAllFree;
            validCounterclockwise <= ccwAllFree;
        end
    end

endmodule

`default_nettype wire

/* tb/rotationCheckModel.svh */
`ifndef ROTATION_CHECK_MODEL_SVH
`define ROTATION_CHECK_MODEL_SVH

// cells at angle 0 as offsets from the pivot
// rows grow downward, columns grow to the right
function automatic void spawnCells(input pieceKindT kind, output int rows[4], output int cols[4]);
    case (kind)
        pieceL: begin
            rows = '{0, 0, 0, -1};
            cols = '{-1, 0, 1, 1};
        end
        pieceJ: begin
            rows = '{0, 0, 0, -1};
            cols = '{-1, 0, 1, -1};
        end
        pieceS: begin
            rows = '{0, 0, -1, -1};
            cols = '{-1, 0, 0, 1};
        end
        pieceZ: begin
            rows = '{-1, 0, -1, 0};
            cols = '{-1, 0, 0, 1};
        end
        pieceI: begin
            rows = '{0, 0, 0, 0};
            cols = '{-1, 0, 1, 2};
        end
        pieceT: begin
            rows = '{0, 0, 0, -1};
            cols = '{-1, 0, 1, 0};
        end
        default: begin
            rows = '{0, 0, 1, 1};
            cols = '{0, 1, 0, 1};
        end
    endcase
endfunction

// closed form for a number of clockwise quarter turns
function automatic void turnOffset(input int quarter, input int r, input int c,
                                   output int tr, output int tc);
    case (quarter)
        1: begin
            tr = c;
            tc = -r;
        end
        2: begin
            tr = -r;
            tc = -c;
        end
        3: begin
            tr = -c;
            tc = r;
        end
        default: begin
            tr = r;
            tc = c;
        end
    endcase
endfunction

// absolute target cells, rows left unclipped
function automatic void targetCells(input pieceKindT kind, input angleT angle, input int step,
                                    input int pivotRow, input int pivotCol,
                                    output int rows[4], output int cols[4]);
    int baseRows[4];
    int baseCols[4];
    int quarter;
    int dr;
    int dc;
    spawnCells(kind, baseRows, baseCols);
    quarter = (int'(angle) + step) % 4;
    for (int i = 0; i < 4; i++) begin
        turnOffset(quarter, baseRows[i], baseCols[i], dr, dc);
        rows[i] = pivotRow + dr;
        cols[i] = ((pivotCol + dc) % boardWidth + boardWidth) % boardWidth;
    end
endfunction

function automatic logic expectValid(input boardT occupancy, input pieceKindT kind,
                                     input angleT angle, input int step,
                                     input int pivotRow, input int pivotCol);
    int rows[4];
    int cols[4];
    logic valid;
    valid = 1'b1;
    targetCells(kind, angle, step, pivotRow, pivotCol, rows, cols);
    // the square never changes, so it always fits
    if (kind != pieceO) begin
        for (int i = 0; i < 4; i++) begin
            if (rows[i] < 0 || rows[i] >= boardHeight) begin
                valid = 1'b0;
            end else if (occupancy[rows[i] * boardWidth + cols[i]]) begin
                valid = 1'b0;
            end
        end
    end
    return valid;
endfunction

// 16-bit Galois LFSR, shifts right
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
endfunction

`endif

/* tb/rotationCheckTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rotationCheckTb
    import boardPkg::*, piecePkg::*;
();

    localparam int resetCycles = 8;
    localparam int resetTimeout = 20;
    localparam int randomCount = 200;
    localparam logic [15:0] lfsrSeed = 16'd20133;

    logic       clk;
    logic       rst;
    boardT      board;
    pieceStateT piece;
    logic       validClockwise;
    logic       validCounterclockwise;
    logic [15:0] lfsrState;

    `include "rotationCheckModel.svh"

    rotationCheck dut0 (
        .clk                  (clk),
        .rst                  (rst),
        .board                (board),
        .piece                (piece),
        .validClockwise       (validClockwise),
        .validCounterclockwise(validCounterclockwise)
    );

    bind rotationCheck rotationCheck_asserts asserts0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic checkVerdict(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "verdict mismatch on %s", name);
        end
    endtask

    function automatic pieceStateT makePiece(input pieceKindT kind, input angleT angle,
                                             input int row, input int col);
        pieceStateT p;
        p.kind = kind;
        p.angle = angle;
        p.pivot.row = rowT'(row);
        p.pivot.col = colT'(col);
        return p;
    endfunction

    // drive on a falling edge, read back one falling edge later
    task automatic askAndCheck(input boardT occupancy, input pieceStateT state,
                               input logic expCw, input logic expCcw);
        @(negedge clk);
        board = occupancy;
        piece = state;
        @(negedge clk);
        checkVerdict("validClockwise", expCw, validClockwise);
        checkVerdict("validCounterclockwise", expCcw, validCounterclockwise);
    endtask

    task automatic takeBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic resetBehavior();
        int edges;
        logic inReset;
        logic released;
        edges = 0;
        released = 1'b0;
        while (!released) begin
            @(posedge clk);
            inReset = rst;
            @(negedge clk);
            edges++;
            if (edges > resetTimeout) begin
                $display("reset stayed asserted for more than %0d cycles", resetTimeout);
                $display("TEST FAILED");
                $fatal(1, "reset timeout");
            end
            if (inReset) begin
                checkVerdict("validClockwise", 1'b0, validClockwise);
                checkVerdict("validCounterclockwise", 1'b0, validCounterclockwise);
            end else begin
                // first edge after release sees the full board and an L
                released = 1'b1;
                checkVerdict("validClockwise", expectValid(board, piece.kind, piece.angle,
                             turnClockwise, piece.pivot.row, piece.pivot.col), validClockwise);
                checkVerdict("validCounterclockwise", expectValid(board, piece.kind,
                             piece.angle, turnCounterclockwise, piece.pivot.row,
                             piece.pivot.col), validCounterclockwise);
            end
        end
    endtask

    task automatic emptyBoardTurns();
        for (int k = 0; k < 7; k++) begin
            for (int a = 0; a < 4; a++) begin
                askAndCheck('0, makePiece(pieceKindT'(k), angleT'(a), 10, 5), 1'b1, 1'b1);
            end
        end
    endtask

    task automatic fullBoardTurns();
        logic squareOnly;
        for (int k = 0; k < 7; k++) begin
            squareOnly = (pieceKindT'(k) == pieceO);
            for (int a = 0; a < 4; a++) begin
                askAndCheck('1, makePiece(pieceKindT'(k), angleT'(a), 10, 5),
                            squareOnly, squareOnly);
            end
        end
    endtask

    // one obstacle on a cell only the given direction needs
    task automatic obstacleCase(input pieceKindT kind, input angleT angle,
                                input int row, input int col, input int step);
        int stepRows[4];
        int stepCols[4];
        int otherRows[4];
        int otherCols[4];
        int pick;
        logic shared;
        boardT occupancy;
        targetCells(kind, angle, step, row, col, stepRows, stepCols);
        targetCells(kind, angle, 4 - step, row, col, otherRows, otherCols);
        pick = -1;
        for (int i = 0; i < 4; i++) begin
            shared = 1'b0;
            for (int j = 0; j < 4; j++) begin
                if (stepRows[i] == otherRows[j] && stepCols[i] == otherCols[j]) begin
                    shared = 1'b1;
                end
            end
            if (!shared) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            occupancy = '0;
            occupancy[stepRows[pick] * boardWidth + stepCols[pick]] = 1'b1;
            askAndCheck(occupancy, makePiece(kind, angle, row, col),
                        expectValid(occupancy, kind, angle, turnClockwise, row, col),
                        expectValid(occupancy, kind, angle, turnCounterclockwise, row, col));
        end
    endtask

    task automatic singleObstacles();
        for (int k = 1; k < 7; k++) begin
            for (int a = 0; a < 4; a++) begin
                obstacleCase(pieceKindT'(k), angleT'(a), 10, 5, turnClockwise);
                obstacleCase(pieceKindT'(k), angleT'(a), 10, 5, turnCounterclockwise);
            end
        end
        // vertical I at the side walls, target cell wraps across
        obstacleCase(pieceI, angle90, 10, 0, turnClockwise);
        obstacleCase(pieceI, angle90, 10, 9, turnCounterclockwise);
    endtask

    task automatic edgeRowTurns();
        int row;
        for (int e = 0; e < 2; e++) begin
            row = (e == 0) ? 0 : boardHeight - 1;
            for (int k = 0; k < 7; k++) begin
                for (int a = 0; a < 4; a++) begin
                    askAndCheck('0, makePiece(pieceKindT'(k), angleT'(a), row, 4),
                        expectValid('0, pieceKindT'(k), angleT'(a), turnClockwise, row, 4),
                        expectValid('0, pieceKindT'(k), angleT'(a), turnCounterclockwise,
                                    row, 4));
                end
            end
        end
    endtask

    task automatic drawQuestion(output boardT occupancy, output pieceStateT state);
        int value;
        int kind;
        int angle;
        int row;
        for (int i = 0; i < boardCells; i++) begin
            // roughly a quarter of the cells occupied
            takeBits(2, value);
            occupancy[i] = (value == 3);
        end
        takeBits(3, kind);
        takeBits(2, angle);
        takeBits(5, row);
        takeBits(4, value);
        state = makePiece(pieceKindT'(kind % 7), angleT'(angle), row % boardHeight,
                          value % boardWidth);
    endtask

    // new question every cycle, result checked one cycle later
    task automatic randomQuestions();
        boardT nextBoard;
        pieceStateT nextPiece;
        logic expCw;
        logic expCcw;
        logic pending;
        pending = 1'b0;
        lfsrState = lfsrSeed;
        for (int n = 0; n <= randomCount; n++) begin
            @(negedge clk);
            if (pending) begin
                checkVerdict("validClockwise", expCw, validClockwise);
                checkVerdict("validCounterclockwise", expCcw, validCounterclockwise);
            end
            if (n < randomCount) begin
                drawQuestion(nextBoard, nextPiece);
                board = nextBoard;
                piece = nextPiece;
                expCw = expectValid(nextBoard, nextPiece.kind, nextPiece.angle,
                                    turnClockwise, nextPiece.pivot.row, nextPiece.pivot.col);
                expCcw = expectValid(nextBoard, nextPiece.kind, nextPiece.angle,
                                     turnCounterclockwise, nextPiece.pivot.row,
                                     nextPiece.pivot.col);
                pending = 1'b1;
            end
        end
    endtask

    initial begin
        board = '1;
        piece = makePiece(pieceL, angle0, 10, 5);
        lfsrState = lfsrSeed;
        resetBehavior();
        emptyBoardTurns();
        fullBoardTurns();
        singleObstacles();
        edgeRowTurns();
        randomQuestions();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rotationCheck_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rotationCheck_asserts
    import boardPkg::*, piecePkg::*;
(
    input logic       clk,
    input logic       rst,
    input boardT      board,
    input pieceStateT piece,
    input logic       validClockwise,
    input logic       validCounterclockwise
);

    // outputs cleared by a reset edge
    resetClears: assert property (
        @(posedge clk) rst |=> (!validClockwise && !validCounterclockwise)
    ) else $error("verdicts not cleared after a reset edge");

    // a square asked now may turn both ways on the next edge
    squareTurns: assert property (
        @(posedge clk) (!rst && piece.kind == pieceO)
            |=> (validClockwise && validCounterclockwise)
    ) else $error("square piece not allowed to turn one cycle later");

    // a full board blocks every other kind on the next edge
    fullBoardBlocks: assert property (
        @(posedge clk) (!rst && (&board) && piece.kind != pieceO)
            |=> (!validClockwise && !validCounterclockwise)
    ) else $error("turn allowed on a full board one cycle later");

    noUnknown: assert property (
        @(posedge clk) !rst |=> !$isunknown({validClockwise, validCounterclockwise})
    ) else $error("verdict outputs are unknown after reset");

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tb
src/boardPkg.sv
src/piecePkg.sv
src/cellLookup.sv
src/rotationProbe.sv
src/rotationVerdict.sv
src/rotationCheck.sv
tb/rotationCheck_asserts.sv
tb/rotationCheckTb.sv
